/* common/fetch_pkg.sv */
package fetch_pkg;

    // widths fixed by the rv64 isa
    localparam int ADDR_W = 64;
    localparam int INST_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [INST_W-1:0] inst_t;

    // first fetch address after reset
    localparam addr_t RESET_PC = 64'h0000_0000_8000_0000;

    // no compressed instructions, so every step is one word
    localparam addr_t PC_STEP = 64'd4;

    // fetch controller states
    // FS_REQ  present a new address
    // FS_WAIT read in flight, result will be used
    // FS_DROP read in flight, result is stale
    typedef enum logic [1:0] {
        FS_REQ  = 2'd0,
        FS_WAIT = 2'd1,
        FS_DROP = 2'd2
    } fetch_state_e;

    // cause of a pc redirect, in decreasing priority after RD_NONE
    typedef enum logic [1:0] {
        RD_NONE = 2'd0,
        RD_JAL  = 2'd1,
        RD_JALR = 2'd2,
        RD_TRAP = 2'd3
    } redirect_e;

endpackage

/* common/mem_pkg.sv */
package mem_pkg;

    // read port widths
    localparam int MEM_DATA_W = 64;
    localparam int MEM_SIZE_W = 8;

    typedef logic [MEM_DATA_W-1:0] mem_data_t;
    typedef logic [MEM_SIZE_W-1:0] mem_size_t;

    // byte lane mask for a 4-byte read
    localparam mem_size_t RD_SIZE_WORD = 8'b0000_1111;

endpackage

/* common/mem_rd_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface mem_rd_if;
    import fetch_pkg::*;
    import mem_pkg::*;

    // address phase
    addr_t     addr;
    mem_size_t size;
    logic      rvalid;
    logic      rready;

    // data phase
    mem_data_t rdata;
    logic      dvalid;
    logic      dready;

    // fetch side of the port
    modport req (
        output addr, size, rvalid, dready,
        input  rready, rdata, dvalid
    );

    // memory side, as seen from the top level pins
    modport sys (
        input  addr, size, rvalid, dready,
        output rready, rdata, dvalid
    );

endinterface

`default_nettype wire

/* fetch/branch_target.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_target (
    input  wire logic             jal_i,
    input  wire logic             jalr_i,
    input  wire logic             branch_i,
    input  wire logic             trap_i,
    input  wire fetch_pkg::addr_t alu_res_i,
    input  wire fetch_pkg::addr_t ex_pc_i,
    input  wire fetch_pkg::addr_t imm_i,
    input  wire fetch_pkg::addr_t rs1_data_i,
    input  wire fetch_pkg::addr_t mtvec_i,
    output logic                  redirect_valid_o,
    output fetch_pkg::addr_t      target_o
);
    import fetch_pkg::*;

    redirect_e cause;
    logic      branch_taken;
    addr_t     jalr_sum;

    // branch compare result arrives as a zero alu result
    assign branch_taken = branch_i && (alu_res_i == '0);
    assign jalr_sum     = rs1_data_i + imm_i;

    always_comb begin
        if (jal_i || branch_taken) begin
            cause = RD_JAL;
        end else if (jalr_i) begin
            cause = RD_JALR;
        end else if (trap_i) begin
            cause = RD_TRAP;
        end else begin
            cause = RD_NONE;
        end
    end

    always_comb begin
        case (cause)
            RD_JAL:  target_o = ex_pc_i + imm_i;
            // jalr clears bit 0 of the sum
            RD_JALR: target_o = {jalr_sum[ADDR_W-1:1], 1'b0};
            RD_TRAP: target_o = mtvec_i;
            default: target_o = ex_pc_i;
        endcase
    end

    assign redirect_valid_o = (cause != RD_NONE);

endmodule

`default_nettype wire

/* fetch/fetch_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_ctrl (
    input  wire logic clk,
    input  wire logic rst_i,
    input  wire logic redirect_valid_i,
    input  wire logic addr_acc_i,
    input  wire logic data_acc_i,
    input  wire logic stall_i,
    output logic      req_start_o,
    output logic      data_take_o,
    output logic      out_load_o,
    output logic      advance_o
);
    import fetch_pkg::*;

    fetch_state_e state_q;
    fetch_state_e state_d;

    // address phase of the current read is done
    logic addr_done_q;
    logic data_edge;

    assign data_edge = addr_done_q && data_acc_i;

    always_comb begin
        state_d     = state_q;
        req_start_o = 1'b0;
        data_take_o = 1'b0;
        out_load_o  = 1'b0;
        advance_o   = 1'b0;

        case (state_q)
            FS_REQ: begin
                // hold off while the pc is being redirected
                if (!redirect_valid_i) begin
                    req_start_o = 1'b1;
                    state_d     = FS_WAIT;
                end
            end
            FS_WAIT: begin
                if (data_edge) begin
                    data_take_o = 1'b1;
                    state_d     = FS_REQ;
                    // redirect on the data edge makes this word stale
                    if (!redirect_valid_i) begin
                        out_load_o = 1'b1;
                        advance_o  = !stall_i;
                    end
                end else if (redirect_valid_i) begin
                    state_d = FS_DROP;
                end
            end
            FS_DROP: begin
                // finish the handshake, throw the word away
                if (data_edge) begin
                    data_take_o = 1'b1;
                    state_d     = FS_REQ;
                end
            end
            default: begin
                state_d = FS_REQ;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= FS_REQ;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            addr_done_q <= 1'b0;
        end else if (data_take_o) begin
            addr_done_q <= 1'b0;
        end else if (addr_acc_i) begin
            addr_done_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* fetch/fetch_port.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_port (
    input  wire logic             clk,
    input  wire logic             rst_i,
    input  wire logic             req_start_i,
    input  wire logic             data_take_i,
    input  wire logic             out_load_i,
    input  wire fetch_pkg::addr_t pc_i,
    mem_rd_if.req                 mem,
    output logic                  addr_acc_o,
    output logic                  data_acc_o,
    output logic                  inst_valid_o,
    output fetch_pkg::inst_t      inst_o,
    output fetch_pkg::addr_t      pc_o
);
    import fetch_pkg::*;
    import mem_pkg::*;

    addr_t addr_q;
    logic  rvalid_q;
    logic  dready_q;
    logic  inst_valid_q;
    inst_t inst_q;
    addr_t pc_q;

    // handshake levels back to the controller
    assign addr_acc_o = rvalid_q && mem.rready;
    assign data_acc_o = mem.dvalid && dready_q;

    // address stays put until the read is finished
    always_ff @(posedge clk) begin
        if (req_start_i) begin
            addr_q <= pc_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rvalid_q <= 1'b0;
        end else if (req_start_i) begin
            rvalid_q <= 1'b1;
        end else if (addr_acc_o) begin
            rvalid_q <= 1'b0;
        end
    end

    // dready follows the address handshake by one cycle
    always_ff @(posedge clk) begin
        if (rst_i) begin
            dready_q <= 1'b0;
        end else if (data_take_i) begin
            dready_q <= 1'b0;
        end else if (addr_acc_o) begin
            dready_q <= 1'b1;
        end
    end

    // one cycle pulse per accepted word
    always_ff @(posedge clk) begin
        if (rst_i) begin
            inst_valid_q <= 1'b0;
        end else begin
            inst_valid_q <= out_load_i;
        end
    end

    always_ff @(posedge clk) begin
        if (out_load_i) begin
            inst_q <= mem.rdata[INST_W-1:0];
            pc_q   <= addr_q;
        end
    end

    assign mem.addr   = addr_q;
    assign mem.size   = RD_SIZE_WORD;
    assign mem.rvalid = rvalid_q;
    assign mem.dready = dready_q;

    assign inst_valid_o = inst_valid_q;
    assign inst_o       = inst_q;
    assign pc_o         = pc_q;

endmodule

`default_nettype wire

/* fetch/pc_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module pc_gen (
    input  wire logic             clk,
    input  wire logic             rst_i,
    input  wire logic             advance_i,
    input  wire logic             redirect_valid_i,
    input  wire fetch_pkg::addr_t target_i,
    output fetch_pkg::addr_t      pc_o
);
    import fetch_pkg::*;

    addr_t pc_q;
    addr_t pc_d;

    // redirect wins over the sequential step
    always_comb begin
        if (redirect_valid_i) begin
            pc_d = target_i;
        end else if (advance_i) begin
            pc_d = pc_q + PC_STEP;
        end else begin
            pc_d = pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

/* flist.f */
common/fetch_pkg.sv
common/mem_pkg.sv
common/mem_rd_if.sv
fetch/fetch_ctrl.sv
fetch/pc_gen.sv
fetch/branch_target.sv
fetch/fetch_port.sv
source/ifetch_top.sv
verif/tb_clk_gen.sv
verif/tb_ifetch.sv

/* source/ifetch_top.sv */
`timescale 1ns/1ns
`default_nettype none

module ifetch_top (
    input  wire logic                clk,
    input  wire logic                rst_i,
    input  wire logic                jal_i,
    input  wire logic                jalr_i,
    input  wire logic                branch_i,
    input  wire logic                trap_i,
    input  wire fetch_pkg::addr_t    alu_res_i,
    input  wire fetch_pkg::addr_t    ex_pc_i,
    input  wire fetch_pkg::addr_t    imm_i,
    input  wire fetch_pkg::addr_t    rs1_data_i,
    input  wire fetch_pkg::addr_t    mtvec_i,
    input  wire logic                stall_i,
    output fetch_pkg::addr_t         mem_addr_o,
    output mem_pkg::mem_size_t       mem_size_o,
    output logic                     mem_rvalid_o,
    input  wire logic                mem_rready_i,
    input  wire mem_pkg::mem_data_t  mem_rdata_i,
    input  wire logic                mem_dvalid_i,
    output logic                     mem_dready_o,
    output logic                     inst_valid_o,
    output fetch_pkg::inst_t         inst_o,
    output fetch_pkg::addr_t         pc_o
);

    logic             redirect_valid;
    fetch_pkg::addr_t target;
    fetch_pkg::addr_t pc;
    logic             advance;
    logic             req_start;
    logic             data_take;
    logic             out_load;
    logic             addr_acc;
    logic             data_acc;

    mem_rd_if mem_bus ();

    // memory port pins
    assign mem_addr_o     = mem_bus.addr;
    assign mem_size_o     = mem_bus.size;
    assign mem_rvalid_o   = mem_bus.rvalid;
    assign mem_dready_o   = mem_bus.dready;
    assign mem_bus.rready = mem_rready_i;
    assign mem_bus.rdata  = mem_rdata_i;
    assign mem_bus.dvalid = mem_dvalid_i;

    fetch_ctrl u_fetch_ctrl (
        .clk              (clk),
        .rst_i            (rst_i),
        .redirect_valid_i (redirect_valid),
        .addr_acc_i       (addr_acc),
        .data_acc_i       (data_acc),
        .stall_i          (stall_i),
        .req_start_o      (req_start),
        .data_take_o      (data_take),
        .out_load_o       (out_load),
        .advance_o        (advance)
    );

    pc_gen u_pc_gen (
        .clk              (clk),
        .rst_i            (rst_i),
        .advance_i        (advance),
        .redirect_valid_i (redirect_valid),
        .target_i         (target),
        .pc_o             (pc)
    );

    branch_target u_branch_target (
        .jal_i            (jal_i),
        .jalr_i           (jalr_i),
        .branch_i         (branch_i),
        .trap_i           (trap_i),
        .alu_res_i        (alu_res_i),
        .ex_pc_i          (ex_pc_i),
        .imm_i            (imm_i),
        .rs1_data_i       (rs1_data_i),
        .mtvec_i          (mtvec_i),
        .redirect_valid_o (redirect_valid),
        .target_o         (target)
    );

    fetch_port u_fetch_port (
        .clk          (clk),
        .rst_i        (rst_i),
        .req_start_i  (req_start),
        .data_take_i  (data_take),
        .out_load_i   (out_load),
        .pc_i         (pc),
        .mem          (mem_bus.req),
        .addr_acc_o   (addr_acc),
        .data_acc_o   (data_acc),
        .inst_valid_o (inst_valid_o),
        .inst_o       (inst_o),
        .pc_o         (pc_o)
    );

endmodule

`default_nettype wire

/* verif/ifetch_input.txt */
# mem <addr> <word>   out <number of outputs>
# evt <out idx> <jal> <jalr> <branch> <trap> <stall> <slow> <alu> <ex_pc> <imm> <rs1> <mtvec> <redirect> <target>
mem 80000000 00000093
mem 80000004 00100113
mem 80000008 0480006f
mem 80000050 00208193
mem 80000054 02000663
mem 80000080 00518233
mem 80000084 40628333
mem 80000088 010083e7
mem 80000110 0200006f
mem 80000130 00000073
mem 80000200 34202573
mem 80000204 00a50593
mem 80000208 1000006f
mem 80000308 00b58613
mem 8000030c 00c606b3
out 16
evt 2 1 0 0 0 0 0 0 80000008 48 0 0 1 80000050
evt 4 0 0 1 0 0 0 0 80000054 2c 0 0 1 80000080
evt 5 0 0 1 0 0 0 5 80000080 40 0 0 0 0
evt 7 0 1 0 0 0 0 0 0 10 80000101 0 1 80000110
evt 8 1 1 0 0 0 0 0 80000110 20 80000001 0 1 80000130
evt 9 0 0 0 1 0 0 0 0 0 0 80000200 1 80000200
evt 10 0 0 0 0 1 0 0 0 0 0 0 0 0
evt 13 1 0 0 0 0 1 0 80000208 100 0 0 1 80000308

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst_o
);

    initial begin
        clk   = 1'b0;
        rst_o = 1'b1;
        forever #10 clk = ~clk;
    end

    // hold reset for five rising edges
    initial begin
        repeat (5) @(posedge clk);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

/* verif/tb_ifetch.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_ifetch;
    import fetch_pkg::*;
    import mem_pkg::*;

    localparam int TIMEOUT = 100;
    localparam int MAX_EV  = 16;
    localparam int MAX_IMG = 32;

    logic clk, rst_i, jal_i, jalr_i, branch_i, trap_i, stall_i;
    addr_t alu_res_i, ex_pc_i, imm_i, rs1_data_i, mtvec_i;
    addr_t mem_addr_o, pc_o;
    mem_size_t mem_size_o;
    logic mem_rvalid_o, mem_rready_i, mem_dvalid_i, mem_dready_o, inst_valid_o;
    mem_data_t mem_rdata_i;
    inst_t inst_o;

    addr_t img_addr [MAX_IMG];
    inst_t img_word [MAX_IMG];
    int img_count, ev_count, num_out, error_count;
    int ev_idx [MAX_EV], ev_flag [MAX_EV][6], ev_redir [MAX_EV];
    addr_t ev_alu [MAX_EV], ev_expc [MAX_EV], ev_imm [MAX_EV], ev_rs1 [MAX_EV];
    addr_t ev_mtvec [MAX_EV], ev_tgt [MAX_EV];
    logic [15:0] lfsr_q;
    logic force_slow, stall_on;

    tb_clk_gen u_clk_gen (.clk(clk), .rst_o(rst_i));

    ifetch_top u_dut (
        .clk(clk), .rst_i(rst_i), .jal_i(jal_i), .jalr_i(jalr_i), .branch_i(branch_i),
        .trap_i(trap_i), .alu_res_i(alu_res_i), .ex_pc_i(ex_pc_i), .imm_i(imm_i),
        .rs1_data_i(rs1_data_i), .mtvec_i(mtvec_i), .stall_i(stall_i),
        .mem_addr_o(mem_addr_o), .mem_size_o(mem_size_o), .mem_rvalid_o(mem_rvalid_o),
        .mem_rready_i(mem_rready_i), .mem_rdata_i(mem_rdata_i),
        .mem_dvalid_i(mem_dvalid_i), .mem_dready_o(mem_dready_o),
        .inst_valid_o(inst_valid_o), .inst_o(inst_o), .pc_o(pc_o)
    );

    task automatic report_error(input string what, input logic [63:0] exp, got);
        error_count++;
        $display("** Error @ %0t ns: %s expected %h got %h", $time, what, exp, got);
        $display("TESTS FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic check_inst(input inst_t got, exp, input string what);
        if (got !== exp) report_error(what, exp, got);
    endtask

    task automatic check_addr(input addr_t got, exp, input string what);
        if (got !== exp) report_error(what, exp, got);
    endtask

    task automatic check_size(input mem_size_t got, exp, input string what);
        if (got !== exp) report_error(what, exp, got);
    endtask

    task automatic check_flag(input logic got, exp, input string what);
        if (got !== exp) report_error(what, exp, got);
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: no %s within %0d cycles", what, TIMEOUT);
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    endtask

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        repeat (n) begin
            lfsr_q = lfsr_step(lfsr_q);
            val = (val << 1) | lfsr_q[0];
        end
    endtask

    // words outside the image get a pattern folded from the full address
    function automatic inst_t image_word(input addr_t a);
        for (int i = 0; i < img_count; i++) begin
            if (img_addr[i] == a) return img_word[i];
        end
        return a[63:32] ^ a[31:0] ^ 32'h6f5a_0013;
    endfunction

    // jal or taken branch first, then jalr, then trap
    function automatic logic ref_redirect(input int i, output addr_t tgt);
        addr_t sum;
        sum = ev_rs1[i] + ev_imm[i];
        tgt = '0;
        if (ev_flag[i][0] || (ev_flag[i][2] && ev_alu[i] == '0)) tgt = ev_expc[i] + ev_imm[i];
        else if (ev_flag[i][1]) tgt = {sum[63:1], 1'b0};
        else if (ev_flag[i][3]) tgt = ev_mtvec[i];
        else return 1'b0;
        return 1'b1;
    endfunction

    task automatic load_input();
        int fd, n;
        logic [8*200-1:0] line;
        logic [8*8-1:0] tag;
        fd = $fopen("verif/ifetch_input.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/ifetch_input.txt");
            $display("TESTS FAILED");
            $fatal(1, "missing input file");
        end
        while (!$feof(fd)) begin
            line = '0;
            n = $fgets(line, fd);
            if ($sscanf(line, "%s", tag) == 1) begin
                if (tag == "mem") begin
                    n = $sscanf(line, "mem %h %h", img_addr[img_count], img_word[img_count]);
                    img_count++;
                end else if (tag == "out") begin
                    n = $sscanf(line, "out %d", num_out);
                end else if (tag == "evt") begin
                    n = $sscanf(line, "evt %d %d %d %d %d %d %d %h %h %h %h %h %d %h",
                        ev_idx[ev_count], ev_flag[ev_count][0], ev_flag[ev_count][1],
                        ev_flag[ev_count][2], ev_flag[ev_count][3], ev_flag[ev_count][4],
                        ev_flag[ev_count][5], ev_alu[ev_count], ev_expc[ev_count],
                        ev_imm[ev_count], ev_rs1[ev_count], ev_mtvec[ev_count],
                        ev_redir[ev_count], ev_tgt[ev_count]);
                    ev_count++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_output();
        int t;
        t = 0;
        @(negedge clk);
        while (inst_valid_o !== 1'b1) begin
            t++;
            if (t > TIMEOUT) report_timeout("fetched instruction");
            @(negedge clk);
        end
    endtask

    // returns once the read in flight has passed its address phase
    task automatic wait_data_phase();
        int t;
        t = 0;
        @(negedge clk);
        while (mem_dready_o !== 1'b1) begin
            t++;
            if (t > TIMEOUT) report_timeout("address handshake");
            @(negedge clk);
        end
    endtask

    // drive one redirect or stall event for a single cycle
    task automatic apply_event(input int i, inout addr_t next_pc);
        addr_t tgt;
        logic hit;
        if (ev_flag[i][4] != 0) begin
            @(posedge clk);
            stall_i <= 1'b1;
            stall_on = 1'b1;
        end else begin
            hit = ref_redirect(i, tgt);
            check_flag(hit, ev_redir[i] != 0, "redirect taken");
            if (hit) check_addr(tgt, ev_tgt[i], "redirect target");
            force_slow = (ev_flag[i][5] != 0);
            // slow case lands the redirect inside the long dvalid delay
            if (force_slow) wait_data_phase();
            @(posedge clk);
            jal_i <= ev_flag[i][0] != 0;
            jalr_i <= ev_flag[i][1] != 0;
            branch_i <= ev_flag[i][2] != 0;
            trap_i <= ev_flag[i][3] != 0;
            alu_res_i <= ev_alu[i];
            ex_pc_i <= ev_expc[i];
            imm_i <= ev_imm[i];
            rs1_data_i <= ev_rs1[i];
            mtvec_i <= ev_mtvec[i];
            @(posedge clk);
            {jal_i, jalr_i, branch_i, trap_i} <= 4'b0000;
            if (hit) next_pc = tgt;
        end
    endtask

    // memory model serving one read at a time with random delays
    initial begin
        int d, t;
        inst_t w;
        addr_t a;
        mem_rready_i = 1'b0;
        mem_dvalid_i = 1'b0;
        mem_rdata_i = '0;
        forever begin
            t = 0;
            @(negedge clk);
            while (mem_rvalid_o !== 1'b1) begin
                t++;
                if (t > TIMEOUT) report_timeout("read request");
                @(negedge clk);
            end
            check_size(mem_size_o, RD_SIZE_WORD, "read size");
            a = mem_addr_o;
            w = image_word(a);
            take_bits(2, d);
            repeat (d) @(negedge clk);
            @(posedge clk);
            mem_rready_i <= 1'b1;
            // request must hold until the handshake edge
            @(negedge clk);
            check_flag(mem_rvalid_o, 1'b1, "rvalid held");
            check_addr(mem_addr_o, a, "read address held");
            @(posedge clk);
            mem_rready_i <= 1'b0;
            if (force_slow) begin
                d = 8;
                force_slow = 1'b0;
            end else begin
                take_bits(2, d);
            end
            repeat (d) @(posedge clk);
            mem_dvalid_i <= 1'b1;
            mem_rdata_i <= {~w, w};
            t = 0;
            @(negedge clk);
            while (mem_dready_o !== 1'b1) begin
                t++;
                if (t > TIMEOUT) report_timeout("data ready");
                @(negedge clk);
            end
            @(posedge clk);
            mem_dvalid_i <= 1'b0;
        end
    end

    initial begin
        addr_t exp_pc, next_pc;
        int t, next_ev;
        {jal_i, jalr_i, branch_i, trap_i, stall_i} = 5'b00000;
        {alu_res_i, ex_pc_i, imm_i, rs1_data_i, mtvec_i} = '0;
        lfsr_q = 16'd52;
        force_slow = 1'b0;
        stall_on = 1'b0;
        error_count = 0;
        img_count = 0;
        ev_count = 0;
        num_out = 0;
        load_input();
        repeat (2) @(negedge clk);
        check_flag(mem_rvalid_o, 1'b0, "rvalid in reset");
        check_flag(mem_dready_o, 1'b0, "dready in reset");
        check_flag(inst_valid_o, 1'b0, "inst_valid in reset");
        t = 0;
        while (rst_i !== 1'b0) begin
            t++;
            if (t > TIMEOUT) report_timeout("reset release");
            @(negedge clk);
        end
        exp_pc = RESET_PC;
        next_ev = 0;
        for (int k = 0; k < num_out; k++) begin
            wait_output();
            check_addr(pc_o, exp_pc, "output pc");
            check_inst(inst_o, image_word(exp_pc), "output word");
            next_pc = exp_pc + PC_STEP;
            // stall was high across this accept
            if (stall_on) begin
                next_pc = exp_pc;
                @(posedge clk);
                stall_i <= 1'b0;
                stall_on = 1'b0;
            end
            if (next_ev < ev_count && ev_idx[next_ev] == k) begin
                apply_event(next_ev, next_pc);
                next_ev++;
            end
            exp_pc = next_pc;
        end
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
